/* rtl/datapathPkg.sv */
// --------------------
// Shared widths, register indices, IR field positions and ALU opcodes
// All users reference these by scoped name
// --------------------
package datapathPkg;

	// Word and register file geometry
	localparam int dataWidth = 32;
	localparam int regCount = 8;
	localparam int regAddrWidth = 3;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;
	// One bit per register
	typedef logic [regCount-1:0] regMask_t;

	// --------------------
	// Fixed register slots
	// R0 to R3 sit at indices 0 to 3
	localparam regAddr_t regRs = 3'd4;
	localparam regAddr_t regPc = 3'd5;
	localparam regAddr_t regIr = 3'd6;
	localparam regAddr_t regTemp0 = 3'd7;

	// --------------------
	// Low bit of each address field inside IR
	localparam int irFieldA = 14;
	localparam int irFieldB = 0;
	localparam int irFieldC = 25;

	// ALU operations
	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opNotA,
		opPassA,
		opPassB,
		opShl,
		opShr
	} aluOp_t;

endpackage

/* rtl/regSelectIf.sv */
// --------------------
// Masks are one-hot or all zero
// --------------------
interface regSelectIf;

	// Read addresses for the two operand buses
	datapathPkg::regAddr_t rdAddrA;
	datapathPkg::regAddr_t rdAddrB;

	// Write strobes, one bit per register
	datapathPkg::regMask_t loadMask;
	// Clear strobes, win over load in the bank
	datapathPkg::regMask_t clearMask;

	// Selector side drives everything
	modport ctrl (
		output rdAddrA,
		output rdAddrB,
		output loadMask,
		output clearMask
	);

	// Register bank only listens
	modport bank (
		input rdAddrA,
		input rdAddrB,
		input loadMask,
		input clearMask
	);

endinterface

/* rtl/regSelect.sv */
// --------------------
// Purely combinational; IR fields come from the value held before the edge
// --------------------
module regSelect (
	input datapathPkg::word_t ir,
	input datapathPkg::regAddr_t ctrlAddrA,
	input datapathPkg::regAddr_t ctrlAddrB,
	input datapathPkg::regAddr_t ctrlAddrC,
	input logic useIrA,
	input logic useIrB,
	input logic useIrC,
	input logic load,
	input logic clear,
	input datapathPkg::regAddr_t clearAddr,
	regSelectIf.ctrl sel
);

	// Address fields pulled out of the instruction word
	datapathPkg::regAddr_t irAddrA;
	datapathPkg::regAddr_t irAddrB;
	datapathPkg::regAddr_t irAddrC;
	// Final write address after source selection
	datapathPkg::regAddr_t wrAddr;

	// One-hot decode that is all zero when not enabled
	function automatic datapathPkg::regMask_t decodeMask(
		input datapathPkg::regAddr_t addr,
		input logic en
	);
		datapathPkg::regMask_t mask;
		mask = '0;
		if (en) begin
			mask[addr] = 1'b1;
		end
		return mask;
	endfunction

	// --------------------
	// Field extraction
	assign irAddrA = ir[datapathPkg::irFieldA +: datapathPkg::regAddrWidth];
	assign irAddrB = ir[datapathPkg::irFieldB +: datapathPkg::regAddrWidth];
	assign irAddrC = ir[datapathPkg::irFieldC +: datapathPkg::regAddrWidth];

	// Per-bus source choice
	assign sel.rdAddrA = useIrA ? irAddrA : ctrlAddrA;
	assign sel.rdAddrB = useIrB ? irAddrB : ctrlAddrB;
	assign wrAddr = useIrC ? irAddrC : ctrlAddrC;

	// --------------------
	// Strobe decoding
	always_comb begin
		sel.loadMask = decodeMask(wrAddr, load);
		// Clear always uses the control address
		sel.clearMask = decodeMask(clearAddr, clear);
	end

endmodule

/* rtl/regBank.sv */
// --------------------
// Clear beats load on the same register; rstN clears all asynchronously
// --------------------
module regBank (
	input logic clock50,
	input logic rstN,
	input datapathPkg::word_t busC,
	regSelectIf.bank sel,
	output datapathPkg::word_t busA,
	output datapathPkg::word_t busB,
	output datapathPkg::word_t ir
);

	// R0-R3, RS, PC, IR, TEMP0 in index order
	datapathPkg::word_t regs [datapathPkg::regCount];

	// --------------------
	// Register update
	always_ff @(posedge clock50 or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < datapathPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < datapathPkg::regCount; i++) begin
				// Clear has priority
				if (sel.clearMask[i]) begin
					regs[i] <= '0;
				end else if (sel.loadMask[i]) begin
					regs[i] <= busC;
				end
			end
		end
	end

	// --------------------
	// Read ports
	// Both buses see every register, no duplicate slots
	assign busA = regs[sel.rdAddrA];
	assign busB = regs[sel.rdAddrB];

	// Instruction word back to the selector and out
	assign ir = regs[datapathPkg::regIr];

	// --------------------
	// Cleared register must read zero one cycle later
	// even if a load hit it in the same cycle
	for (genvar g = 0; g < datapathPkg::regCount; g++) begin : gClearChk
		assert property (
			@(posedge clock50) disable iff (!rstN)
			sel.clearMask[g] |=> (regs[g] == '0)
		) else $error("regBank: register %0d not cleared", g);
	end

endmodule

/* rtl/alu.sv */
// --------------------
// Combinational; overflow only for add and sub
// --------------------
module alu (
	input datapathPkg::word_t busA,
	input datapathPkg::word_t busB,
	input datapathPkg::aluOp_t aluOp,
	output datapathPkg::word_t result,
	output logic overflow,
	output logic carry,
	output logic negative,
	output logic zero
);

	// Sign bits of the operands
	logic signA;
	logic signB;

	assign signA = busA[datapathPkg::dataWidth-1];
	assign signB = busB[datapathPkg::dataWidth-1];

	// --------------------
	// Operation select and flags
	always_comb begin
		result = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (aluOp)
			datapathPkg::opAdd: begin
				// 33-bit sum with the carry out on top
				{carry, result} = {1'b0, busA} + {1'b0, busB};
				overflow = (signA == signB) &&
					(result[datapathPkg::dataWidth-1] != signA);
			end
			datapathPkg::opSub: begin
				// Top bit set means a borrow when A is below B unsigned
				{carry, result} = {1'b0, busA} - {1'b0, busB};
				overflow = (signA != signB) &&
					(result[datapathPkg::dataWidth-1] != signA);
			end
			datapathPkg::opAnd: result = busA & busB;
			datapathPkg::opOr: result = busA | busB;
			datapathPkg::opXor: result = busA ^ busB;
			datapathPkg::opNotA: result = ~busA;
			datapathPkg::opPassA: result = busA;
			datapathPkg::opPassB: result = busB;
			datapathPkg::opShl: begin
				// Bit leaving the top
				carry = signA;
				result = busA << 1;
			end
			datapathPkg::opShr: begin
				carry = busA[0];
				result = busA >> 1;
			end
			// Unused encodings give zero
			default: result = '0;
		endcase
		negative = result[datapathPkg::dataWidth-1];
		zero = (result == '0);
		// Add carries out exactly when the sum wraps below an operand
		// and sub borrows exactly when A is below B
		assert ((aluOp != datapathPkg::opAdd || carry == (result < busA)) &&
			(aluOp != datapathPkg::opSub || carry == (busA < busB)))
			else $error("alu: carry flag disagrees with operands");
	end

endmodule

/* rtl/datapath.sv */
// --------------------
// All controls are levels sampled at clock50; no handshake
// --------------------
module datapath (
	input logic clock50,
	input logic rstN,
	// Write data and strobes
	input datapathPkg::word_t busC,
	input logic load,
	input logic clear,
	input datapathPkg::regAddr_t clearAddr,
	// Control-field addresses
	input datapathPkg::regAddr_t ctrlAddrA,
	input datapathPkg::regAddr_t ctrlAddrB,
	input datapathPkg::regAddr_t ctrlAddrC,
	// Pick IR field instead of control field
	input logic useIrA,
	input logic useIrB,
	input logic useIrC,
	input datapathPkg::aluOp_t aluOp,
	// ALU result and flags
	output datapathPkg::word_t result,
	output logic overflow,
	output logic carry,
	output logic negative,
	output logic zero,
	// Observation buses
	output datapathPkg::word_t busA,
	output datapathPkg::word_t busB,
	output datapathPkg::word_t ir
);

	// Addresses and strobes from selector to bank
	regSelectIf selBus ();

	// --------------------
	// Address selection and strobe decode
	regSelect iRegSelect (
		.ir (ir),
		.ctrlAddrA (ctrlAddrA),
		.ctrlAddrB (ctrlAddrB),
		.ctrlAddrC (ctrlAddrC),
		.useIrA (useIrA),
		.useIrB (useIrB),
		.useIrC (useIrC),
		.load (load),
		.clear (clear),
		.clearAddr (clearAddr),
		.sel (selBus.ctrl)
	);

	// Storage and read muxes
	regBank iRegBank (
		.clock50 (clock50),
		.rstN (rstN),
		.busC (busC),
		.sel (selBus.bank),
		.busA (busA),
		.busB (busB),
		.ir (ir)
	);

	// --------------------
	// Operates on the two read buses
	alu iAlu (
		.busA (busA),
		.busB (busB),
		.aluOp (aluOp),
		.result (result),
		.overflow (overflow),
		.carry (carry),
		.negative (negative),
		.zero (zero)
	);

endmodule

/* tb/tbDatapath.sv */
// --------------------
// Checks land 10 ns before each rising edge; stimulus moves on falling edges
// Fixed seed gives the same operands on every run
// --------------------
module tbDatapath;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clockPeriod = 40;
	localparam int aluPairs = 12;
	// Reset, reset test, load test, ALU pairs, IR test, clear test
	localparam int testCycles = 4 + 8 + 16 + aluPairs * 12 + 7 + 21;

	// Corner operands paired by index
	localparam datapathPkg::word_t cornerA [6] = '{32'h0000_0000, 32'hFFFF_FFFF,
		32'h7FFF_FFFF, 32'h8000_0000, 32'h8000_0000, 32'h0000_0001};
	localparam datapathPkg::word_t cornerB [6] = '{32'h0000_0000, 32'h0000_0001,
		32'h0000_0001, 32'h0000_0001, 32'h8000_0000, 32'hFFFF_FFFF};

	logic clock50;
	logic rstN;
	datapathPkg::word_t busC;
	logic load;
	logic clear;
	datapathPkg::regAddr_t clearAddr;
	datapathPkg::regAddr_t ctrlAddrA;
	datapathPkg::regAddr_t ctrlAddrB;
	datapathPkg::regAddr_t ctrlAddrC;
	logic useIrA;
	logic useIrB;
	logic useIrC;
	datapathPkg::aluOp_t aluOp;
	datapathPkg::word_t result;
	logic overflow;
	logic carry;
	logic negative;
	logic zero;
	datapathPkg::word_t busA;
	datapathPkg::word_t busB;
	datapathPkg::word_t ir;

	// Register model and counters
	datapathPkg::word_t regModel [datapathPkg::regCount];
	datapathPkg::regAddr_t modelWrAddr;
	int checkCount;
	int errorCount;
	int testChecks;
	int testErrors;

	datapath i_dut (.*);

	initial begin
		clock50 = 1'b0;
		forever begin
			#(clockPeriod / 2) clock50 = ~clock50;
		end
	end

	// --------------------
	// Reference ALU
	// Signed range check for overflow
	function automatic logic outOfRange(input longint v);
		return (v > 64'sd2147483647) || (v < -64'sd2147483648);
	endfunction

	// Packed as overflow, carry, negative, zero, result
	function automatic logic [35:0] refAlu(input datapathPkg::word_t a,
		input datapathPkg::word_t b, input datapathPkg::aluOp_t op);
		datapathPkg::word_t r;
		logic c;
		logic ov;
		longint sa;
		longint sb;
		r = '0;
		c = 1'b0;
		ov = 1'b0;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		case (op)
			datapathPkg::opAdd: begin
				r = a + b;
				c = ({32'd0, a} + {32'd0, b}) > 64'hFFFF_FFFF;
				ov = outOfRange(sa + sb);
			end
			datapathPkg::opSub: begin
				r = a - b;
				// Borrow when A is below B unsigned
				c = a < b;
				ov = outOfRange(sa - sb);
			end
			datapathPkg::opAnd: r = a & b;
			datapathPkg::opOr: r = a | b;
			datapathPkg::opXor: r = a ^ b;
			datapathPkg::opNotA: r = ~a;
			datapathPkg::opPassA: r = a;
			datapathPkg::opPassB: r = b;
			datapathPkg::opShl: begin
				r = {a[30:0], 1'b0};
				c = a[31];
			end
			datapathPkg::opShr: begin
				r = {1'b0, a[31:1]};
				c = a[0];
			end
			default: r = '0;
		endcase
		return {ov, c, r[31], (r == '0), r};
	endfunction

	// --------------------
	// Checking
	task automatic checkValue(input string what, input datapathPkg::word_t got,
		input datapathPkg::word_t exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Every output against the register model
	task automatic compareOutputs();
		datapathPkg::regAddr_t addrA;
		datapathPkg::regAddr_t addrB;
		datapathPkg::word_t irModel;
		logic [35:0] expAlu;
		irModel = regModel[datapathPkg::regIr];
		addrA = useIrA ? irModel[datapathPkg::irFieldA +: datapathPkg::regAddrWidth] : ctrlAddrA;
		addrB = useIrB ? irModel[datapathPkg::irFieldB +: datapathPkg::regAddrWidth] : ctrlAddrB;
		expAlu = refAlu(regModel[addrA], regModel[addrB], aluOp);
		checkValue("model busA", busA, regModel[addrA]);
		checkValue("model busB", busB, regModel[addrB]);
		checkValue("model ir", ir, irModel);
		checkValue("model result", result, expAlu[31:0]);
		checkValue("model flags", {28'd0, overflow, carry, negative, zero},
			{28'd0, expAlu[35:32]});
	endtask

	task automatic finishTest(input string name);
		$display("test %s: %0d checks, %0d errors", name, checkCount - testChecks,
			errorCount - testErrors);
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	// One-cycle load through the control C address
	task automatic loadReg(input datapathPkg::regAddr_t addr, input datapathPkg::word_t value);
		busC = value;
		ctrlAddrC = addr;
		load = 1'b1;
		@(negedge clock50);
		load = 1'b0;
	endtask

	// --------------------
	// Model follows load and clear; IR fields from before the edge
	always @(posedge clock50 or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < datapathPkg::regCount; i++) begin
				regModel[i] = '0;
			end
		end else begin
			modelWrAddr = useIrC ?
				regModel[datapathPkg::regIr][datapathPkg::irFieldC +: datapathPkg::regAddrWidth] :
				ctrlAddrC;
			if (load) begin
				regModel[modelWrAddr] = busC;
			end
			// Applied last so clear wins
			if (clear) begin
				regModel[clearAddr] = '0;
			end
		end
	end

	initial begin
		forever begin
			@(negedge clock50);
			#10;
			if (rstN) begin
				compareOutputs();
			end
		end
	end

	// Watchdog with a margin of 50 cycles
	initial begin
		#(testCycles * clockPeriod + 50 * clockPeriod);
		$display("Timeout: tests did not finish within %0d cycles", testCycles + 50);
		$display("CHECKS FAILED");
		$finish;
	end

	// --------------------
	// Tests
	initial begin
		datapathPkg::word_t opA;
		datapathPkg::word_t opB;
		datapathPkg::word_t newWord;
		datapathPkg::word_t instr;
		datapathPkg::word_t saved [datapathPkg::regCount];
		logic [35:0] expAlu;
		logic [3:0] opBits;
		void'($urandom(82103));
		checkCount = 0;
		errorCount = 0;
		testChecks = 0;
		testErrors = 0;
		rstN = 1'b0;
		busC = '0;
		load = 1'b0;
		clear = 1'b0;
		clearAddr = '0;
		ctrlAddrA = '0;
		ctrlAddrB = '0;
		ctrlAddrC = '0;
		useIrA = 1'b0;
		useIrB = 1'b0;
		useIrC = 1'b0;
		aluOp = datapathPkg::opAdd;
		// Three cycles of reset released between edges
		repeat (3) @(posedge clock50);
		@(negedge clock50);
		rstN = 1'b1;

		// Every slot reads zero
		for (int i = 0; i < datapathPkg::regCount; i++) begin
			ctrlAddrA = i[2:0];
			ctrlAddrB = ~i[2:0];
			#10;
			checkValue("reset busA", busA, '0);
			checkValue("reset busB", busB, '0);
			@(negedge clock50);
		end
		finishTest("reset");

		// Load each slot and read it back the next cycle
		for (int i = 0; i < datapathPkg::regCount; i++) begin
			saved[i] = $urandom();
			loadReg(i[2:0], saved[i]);
			ctrlAddrA = i[2:0];
			ctrlAddrB = i[2:0];
			#10;
			checkValue("load busA", busA, saved[i]);
			checkValue("load busB", busB, saved[i]);
			@(negedge clock50);
		end
		finishTest("load");

		// Operands in R0 and R1 with every opcode per pair
		for (int p = 0; p < aluPairs; p++) begin
			if (p < 6) begin
				opA = cornerA[p];
				opB = cornerB[p];
			end else begin
				opA = $urandom();
				opB = $urandom();
			end
			loadReg(3'd0, opA);
			loadReg(3'd1, opB);
			ctrlAddrA = 3'd0;
			ctrlAddrB = 3'd1;
			for (int k = 0; k <= int'(datapathPkg::opShr); k++) begin
				opBits = k[3:0];
				aluOp = datapathPkg::aluOp_t'(opBits);
				#10;
				expAlu = refAlu(opA, opB, aluOp);
				checkValue($sformatf("alu %s result", aluOp.name()), result, expAlu[31:0]);
				checkValue($sformatf("alu %s flags", aluOp.name()),
					{28'd0, overflow, carry, negative, zero}, {28'd0, expAlu[35:32]});
				@(negedge clock50);
			end
		end
		finishTest("alu");

		// IR names R2 on A, R3 on B, R1 as write target
		saved[0] = $urandom();
		loadReg(3'd0, saved[0]);
		saved[2] = $urandom();
		loadReg(3'd2, saved[2]);
		saved[3] = $urandom();
		loadReg(3'd3, saved[3]);
		instr = $urandom();
		instr[datapathPkg::irFieldA +: datapathPkg::regAddrWidth] = 3'd2;
		instr[datapathPkg::irFieldB +: datapathPkg::regAddrWidth] = 3'd3;
		instr[datapathPkg::irFieldC +: datapathPkg::regAddrWidth] = 3'd1;
		loadReg(datapathPkg::regIr, instr);
		// Control fields point elsewhere
		ctrlAddrA = 3'd0;
		ctrlAddrB = 3'd0;
		useIrA = 1'b1;
		useIrB = 1'b1;
		#10;
		checkValue("ir busA", busA, saved[2]);
		checkValue("ir busB", busB, saved[3]);
		@(negedge clock50);
		newWord = $urandom();
		useIrC = 1'b1;
		loadReg(3'd0, newWord);
		useIrA = 1'b0;
		useIrB = 1'b0;
		useIrC = 1'b0;
		ctrlAddrA = 3'd1;
		ctrlAddrB = 3'd0;
		#10;
		checkValue("ir write target", busA, newWord);
		checkValue("ctrl C untouched", busB, saved[0]);
		@(negedge clock50);
		finishTest("irAddr");

		// Nonzero fill then a clear of R2 alone
		for (int i = 0; i < datapathPkg::regCount; i++) begin
			saved[i] = $urandom() | 32'd1;
			loadReg(i[2:0], saved[i]);
		end
		clearAddr = 3'd2;
		clear = 1'b1;
		@(negedge clock50);
		clear = 1'b0;
		saved[2] = '0;
		for (int i = 0; i < datapathPkg::regCount; i++) begin
			ctrlAddrA = i[2:0];
			#10;
			checkValue($sformatf("clear R%0d", i), busA, saved[i]);
			@(negedge clock50);
		end
		// Clear wins on the same register
		clearAddr = 3'd5;
		clear = 1'b1;
		loadReg(3'd5, $urandom() | 32'd1);
		// Both happen on different registers
		newWord = $urandom() | 32'd1;
		clearAddr = 3'd4;
		loadReg(3'd1, newWord);
		clear = 1'b0;
		ctrlAddrA = 3'd5;
		ctrlAddrB = 3'd4;
		#10;
		checkValue("clear beats load", busA, '0);
		checkValue("clear beside load", busB, '0);
		@(negedge clock50);
		ctrlAddrA = 3'd1;
		#10;
		checkValue("load beside clear", busA, newWord);
		@(negedge clock50);
		finishTest("clear");

		$display("Totals: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
rtl/datapathPkg.sv
rtl/regSelectIf.sv
rtl/regSelect.sv
rtl/regBank.sv
rtl/alu.sv
rtl/datapath.sv
tb/tbDatapath.sv

/* run.sh */
#!/bin/sh
# Builds the datapath testbench with Verilator, runs it and checks the log

buildDir=obj_dir
simName=simDatapath
logFile=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tbDatapath \
	-Mdir "$buildDir" -o "$simName"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$logFile"; then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1
